//--- Makefile
TOOL  = verilator
TOP   = tb_nrv_soc
FLIST = list.f
FLAGS = --binary --timing --assert -j 0
OBJ   = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ)

//--- list.f
nrv_pkg.sv
nrv_port_arbiter.sv
nrv_bus_matrix.sv
nrv_tcm_ram.sv
nrv_gpio_ctrl.sv
nrv_soc_top.sv
nrv_soc_assert.sv
tb_nrv_soc.sv

//--- nrv_bus_matrix.sv
//**************************************************
// Two masters to three slaves, one arbiter per slave
// Masters hold stb and address stable until ack
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_bus_matrix (
   input  logic           clk,
   input  logic           reset,
   // Instruction side, read only
   input  logic           iside_stb,
   input  nrv_pkg::addr_t iside_adr,
   output nrv_pkg::data_t iside_dat_r,
   output logic           iside_ack,
   // Data side
   input  logic           dside_stb,
   input  logic           dside_we,
   input  nrv_pkg::addr_t dside_adr,
   input  nrv_pkg::sel_t  dside_sel,
   input  nrv_pkg::data_t dside_dat_w,
   output nrv_pkg::data_t dside_dat_r,
   output logic           dside_ack,
   // Code RAM
   output logic           tcm0_stb,
   output logic           tcm0_we,
   output nrv_pkg::addr_t tcm0_adr,
   output nrv_pkg::sel_t  tcm0_sel,
   output nrv_pkg::data_t tcm0_dat_w,
   input  nrv_pkg::data_t tcm0_dat_r,
   input  logic           tcm0_ack,
   // Data RAM
   output logic           tcm1_stb,
   output logic           tcm1_we,
   output nrv_pkg::addr_t tcm1_adr,
   output nrv_pkg::sel_t  tcm1_sel,
   output nrv_pkg::data_t tcm1_dat_w,
   input  nrv_pkg::data_t tcm1_dat_r,
   input  logic           tcm1_ack,
   // GPIO
   output logic           gpio_stb,
   output logic           gpio_we,
   output nrv_pkg::addr_t gpio_adr,
   output nrv_pkg::sel_t  gpio_sel,
   output nrv_pkg::data_t gpio_dat_w,
   input  nrv_pkg::data_t gpio_dat_r,
   input  logic           gpio_ack
);

   import nrv_pkg::*;

   region_t    iside_region, dside_region;
   logic [3:0] iside_hit, dside_hit;   // One-hot target, zero when idle
   arb_state_t tcm0_state, tcm1_state, gpio_state;
   logic       iside_nil_ack, dside_nil_ack;   // Unmapped responders

   assign iside_region = region_t'(iside_adr[REGION_MSB:REGION_LSB]);
   assign dside_region = region_t'(dside_adr[REGION_MSB:REGION_LSB]);
   assign iside_hit    = iside_stb ? (4'b0001 << iside_region) : 4'b0000;
   assign dside_hit    = dside_stb ? (4'b0001 << dside_region) : 4'b0000;

   nrv_port_arbiter u_arb_tcm0 (.clk(clk), .reset(reset),
      .iside_req(iside_hit[REGION_TCM0]), .dside_req(dside_hit[REGION_TCM0]),
      .slave_ack(tcm0_ack), .state(tcm0_state));
   nrv_port_arbiter u_arb_tcm1 (.clk(clk), .reset(reset),
      .iside_req(iside_hit[REGION_TCM1]), .dside_req(dside_hit[REGION_TCM1]),
      .slave_ack(tcm1_ack), .state(tcm1_state));
   nrv_port_arbiter u_arb_gpio (.clk(clk), .reset(reset),
      .iside_req(iside_hit[REGION_PERIPH]), .dside_req(dside_hit[REGION_PERIPH]),
      .slave_ack(gpio_ack), .state(gpio_state));

   // Request side, granted master only; iside reads full words
   assign tcm0_stb   = (tcm0_state == ARB_ISIDE) ? iside_hit[REGION_TCM0]
                                                 : (tcm0_state == ARB_DSIDE) && dside_hit[REGION_TCM0];
   assign tcm0_we    = (tcm0_state == ARB_DSIDE) && dside_we;
   assign tcm0_adr   = (tcm0_state == ARB_ISIDE) ? iside_adr : dside_adr;
   assign tcm0_sel   = (tcm0_state == ARB_ISIDE) ? sel_t'('1) : dside_sel;
   assign tcm0_dat_w = dside_dat_w;   // Only dside writes

   assign tcm1_stb   = (tcm1_state == ARB_ISIDE) ? iside_hit[REGION_TCM1]
                                                 : (tcm1_state == ARB_DSIDE) && dside_hit[REGION_TCM1];
   assign tcm1_we    = (tcm1_state == ARB_DSIDE) && dside_we;
   assign tcm1_adr   = (tcm1_state == ARB_ISIDE) ? iside_adr : dside_adr;
   assign tcm1_sel   = (tcm1_state == ARB_ISIDE) ? sel_t'('1) : dside_sel;
   assign tcm1_dat_w = dside_dat_w;

   assign gpio_stb   = (gpio_state == ARB_ISIDE) ? iside_hit[REGION_PERIPH]
                                                 : (gpio_state == ARB_DSIDE) && dside_hit[REGION_PERIPH];
   assign gpio_we    = (gpio_state == ARB_DSIDE) && dside_we;
   assign gpio_adr   = (gpio_state == ARB_ISIDE) ? iside_adr : dside_adr;
   assign gpio_sel   = (gpio_state == ARB_ISIDE) ? sel_t'('1) : dside_sel;
   assign gpio_dat_w = dside_dat_w;

   // Region 3 acks one cycle later, writes dropped
   always_ff @(posedge clk) begin
      if (reset) begin
         iside_nil_ack <= 1'b0;
         dside_nil_ack <= 1'b0;
      end else begin
         iside_nil_ack <= iside_hit[REGION_NONE] && !iside_nil_ack;
         dside_nil_ack <= dside_hit[REGION_NONE] && !dside_nil_ack;
      end
   end

   // Response side, ack only to the granted master
   assign iside_ack = (tcm0_state == ARB_ISIDE && tcm0_ack) || (tcm1_state == ARB_ISIDE && tcm1_ack)
                      || (gpio_state == ARB_ISIDE && gpio_ack) || iside_nil_ack;
   assign dside_ack = (tcm0_state == ARB_DSIDE && tcm0_ack) || (tcm1_state == ARB_DSIDE && tcm1_ack)
                      || (gpio_state == ARB_DSIDE && gpio_ack) || dside_nil_ack;

   always_comb begin
      iside_dat_r = '0;   // Unmapped reads zero
      if (tcm0_state == ARB_ISIDE) begin
         iside_dat_r = tcm0_dat_r;
      end else if (tcm1_state == ARB_ISIDE) begin
         iside_dat_r = tcm1_dat_r;
      end else if (gpio_state == ARB_ISIDE) begin
         iside_dat_r = gpio_dat_r;
      end
   end

   always_comb begin
      dside_dat_r = '0;
      if (tcm0_state == ARB_DSIDE) begin
         dside_dat_r = tcm0_dat_r;
      end else if (tcm1_state == ARB_DSIDE) begin
         dside_dat_r = tcm1_dat_r;
      end else if (gpio_state == ARB_DSIDE) begin
         dside_dat_r = gpio_dat_r;
      end
   end

endmodule

`default_nettype wire

//--- nrv_gpio_ctrl.sv
//**************************************************
// p1 is synchronized, so reads lag the pin by two clocks
// Only byte enables 0 and 1 reach the output register
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_gpio_ctrl (
   input  logic           clk,
   input  logic           reset,
   input  logic           stb,
   input  logic           we,
   input  nrv_pkg::addr_t adr,
   input  nrv_pkg::sel_t  sel,
   input  nrv_pkg::data_t dat_w,
   output nrv_pkg::data_t dat_r,
   output logic           ack,
   output nrv_pkg::gpio_t p0,
   input  nrv_pkg::gpio_t p1
);

   import nrv_pkg::*;

   gpio_t p1_meta, p1_sync;   // Two-flop synchronizer
   logic  hit_out, hit_in;
   logic  access;

   // Word offset within the peripheral region
   assign hit_out = adr[REGION_LSB-1:2] == GPIO_OUT_OFFSET[REGION_LSB-1:2];
   assign hit_in  = adr[REGION_LSB-1:2] == GPIO_IN_OFFSET[REGION_LSB-1:2];
   assign access  = stb && !ack;

   always_ff @(posedge clk) begin
      p1_meta <= p1;
      p1_sync <= p1_meta;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
         p0  <= '0;
      end else begin
         ack <= access;
         if (access && we && hit_out) begin
            if (sel[0]) begin
               p0[7:0] <= dat_w[7:0];
            end
            if (sel[1]) begin
               p0[15:8] <= dat_w[15:8];
            end
         end
      end
   end

   // Read data registered with ack, upper half zero
   always_ff @(posedge clk) begin
      if (access) begin
         if (hit_out) begin
            dat_r <= {16'h0000, p0};
         end else if (hit_in) begin
            dat_r <= {16'h0000, p1_sync};
         end else begin
            dat_r <= '0;   // Unused offset
         end
      end
   end

endmodule

`default_nettype wire

//--- nrv_pkg.sv
//**************************************************
// Region decode looks at address bits 17:16 only
// Upper address bits alias, and sub-word addressing uses sel
//**************************************************
`default_nettype none

package nrv_pkg;

   // Bus widths
   typedef logic [31:0] addr_t;   // Byte address
   typedef logic [31:0] data_t;   // One bus word
   typedef logic [3:0]  sel_t;    // Byte enables, bit n for byte n
   typedef logic [15:0] gpio_t;   // One GPIO port

   // Memory map, one 64 KiB region per slave
   localparam int REGION_LSB = 16;
   localparam int REGION_MSB = 17;

   typedef enum logic [1:0] {
      REGION_TCM0   = 2'd0,   // Code RAM
      REGION_TCM1   = 2'd1,   // Data RAM
      REGION_PERIPH = 2'd2,   // GPIO
      REGION_NONE   = 2'd3    // Unmapped, reads zero
   } region_t;

   // Per-slave arbiter
   typedef enum logic [1:0] {
      ARB_IDLE  = 2'd0,
      ARB_ISIDE = 2'd1,   // Slave owned by instruction side
      ARB_DSIDE = 2'd2    // Slave owned by data side
   } arb_state_t;

   // GPIO register offsets inside the peripheral region
   localparam addr_t GPIO_OUT_OFFSET = 32'h0000_0000;   // p0, bytes 0 and 1
   localparam addr_t GPIO_IN_OFFSET  = 32'h0000_0004;   // p1, read only

endpackage

`default_nettype wire

//--- nrv_port_arbiter.sv
//**************************************************
// Owns one slave; grant held until that slave acks
// Ties alternate, data side counts as last granted after reset
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_port_arbiter (
   input  logic                clk,
   input  logic                reset,
   input  logic                iside_req,   // Instruction side wants this slave
   input  logic                dside_req,   // Data side wants this slave
   input  logic                slave_ack,
   output nrv_pkg::arb_state_t state
);

   import nrv_pkg::*;

   arb_state_t state_nxt;
   logic       last_iside;   // Last grant went to iside

   always_comb begin
      state_nxt = state;
      case (state)
         ARB_IDLE: begin
            // Round robin on a tie
            if (iside_req && (!dside_req || !last_iside)) begin
               state_nxt = ARB_ISIDE;
            end else if (dside_req) begin
               state_nxt = ARB_DSIDE;
            end
         end
         ARB_ISIDE,
         ARB_DSIDE: begin
            if (slave_ack) begin
               state_nxt = ARB_IDLE;   // Transfer done this edge
            end
         end
         default: state_nxt = ARB_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state      <= ARB_IDLE;
         last_iside <= 1'b0;   // So iside wins the first tie
      end else begin
         state <= state_nxt;
         if (state == ARB_IDLE && state_nxt != ARB_IDLE) begin
            last_iside <= (state_nxt == ARB_ISIDE);
         end
      end
   end

endmodule

`default_nettype wire

//--- nrv_soc_assert.sv
//**************************************************
// Bound into every nrv_bus_matrix, quiet during reset
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_soc_assert (
   input logic                clk,
   input logic                reset,
   input logic                iside_stb,
   input logic                iside_ack,
   input logic                dside_stb,
   input logic                dside_ack,
   input nrv_pkg::region_t    iside_region,
   input nrv_pkg::region_t    dside_region,
   input logic                tcm0_stb,
   input logic                tcm1_stb,
   input logic                gpio_stb,
   input nrv_pkg::arb_state_t tcm0_state,
   input nrv_pkg::arb_state_t tcm1_state,
   input nrv_pkg::arb_state_t gpio_state
);

   import nrv_pkg::*;

   // Ack only inside stb, then low again
   a_iside_ack: assert property (@(posedge clk) disable iff (reset)
      iside_ack |-> iside_stb ##1 !iside_ack) else $error("iside_ack outside stb or too long");
   a_dside_ack: assert property (@(posedge clk) disable iff (reset)
      dside_ack |-> dside_stb ##1 !dside_ack) else $error("dside_ack outside stb or too long");

   // Two acks at once come from two slaves; region 3 has one responder per master
   a_one_owner: assert property (@(posedge clk) disable iff (reset)
      iside_ack && dside_ack |-> iside_region != dside_region || iside_region == REGION_NONE)
      else $error("one slave granted to both masters");

   a_tcm0_idle: assert property (@(posedge clk) disable iff (reset)
      tcm0_state == ARB_IDLE |-> !tcm0_stb) else $error("tcm0_stb while idle");
   a_tcm1_idle: assert property (@(posedge clk) disable iff (reset)
      tcm1_state == ARB_IDLE |-> !tcm1_stb) else $error("tcm1_stb while idle");
   a_gpio_idle: assert property (@(posedge clk) disable iff (reset)
      gpio_state == ARB_IDLE |-> !gpio_stb) else $error("gpio_stb while idle");

endmodule

bind nrv_bus_matrix nrv_soc_assert u_assert (
   .clk          (clk),          .reset        (reset),
   .iside_stb    (iside_stb),    .iside_ack    (iside_ack),
   .dside_stb    (dside_stb),    .dside_ack    (dside_ack),
   .iside_region (iside_region), .dside_region (dside_region),
   .tcm0_stb     (tcm0_stb),     .tcm1_stb     (tcm1_stb),     .gpio_stb (gpio_stb),
   .tcm0_state   (tcm0_state),   .tcm1_state   (tcm1_state),   .gpio_state (gpio_state)
);

`default_nettype wire

//--- nrv_soc_top.sv
//**************************************************
// Both bus masters are top-level ports; one clock, clk
// tcm_words sets the depth of both RAMs
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_soc_top #(
   parameter int tcm_words = 16384   // Words per RAM
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           iside_stb,
   input  nrv_pkg::addr_t iside_adr,
   output nrv_pkg::data_t iside_dat_r,
   output logic           iside_ack,
   input  logic           dside_stb,
   input  logic           dside_we,
   input  nrv_pkg::addr_t dside_adr,
   input  nrv_pkg::sel_t  dside_sel,
   input  nrv_pkg::data_t dside_dat_w,
   output nrv_pkg::data_t dside_dat_r,
   output logic           dside_ack,
   output nrv_pkg::gpio_t p0,
   input  nrv_pkg::gpio_t p1
);

   import nrv_pkg::*;

   // Slave segments, named as the matrix ports
   logic  tcm0_stb, tcm1_stb, gpio_stb;
   logic  tcm0_we, tcm1_we, gpio_we;
   addr_t tcm0_adr, tcm1_adr, gpio_adr;
   sel_t  tcm0_sel, tcm1_sel, gpio_sel;
   data_t tcm0_dat_w, tcm1_dat_w, gpio_dat_w;
   data_t tcm0_dat_r, tcm1_dat_r, gpio_dat_r;
   logic  tcm0_ack, tcm1_ack, gpio_ack;

   nrv_bus_matrix u_matrix (.*);   // All ports match by name

   nrv_tcm_ram #(.tcm_words(tcm_words)) u_tcm0 (   // Code RAM
      .clk   (clk),        .reset (reset),
      .stb   (tcm0_stb),   .we    (tcm0_we),    .adr (tcm0_adr),
      .sel   (tcm0_sel),   .dat_w (tcm0_dat_w),
      .dat_r (tcm0_dat_r), .ack   (tcm0_ack)
   );

   nrv_tcm_ram #(.tcm_words(tcm_words)) u_tcm1 (   // Data RAM
      .clk   (clk),        .reset (reset),
      .stb   (tcm1_stb),   .we    (tcm1_we),    .adr (tcm1_adr),
      .sel   (tcm1_sel),   .dat_w (tcm1_dat_w),
      .dat_r (tcm1_dat_r), .ack   (tcm1_ack)
   );

   nrv_gpio_ctrl u_gpio (
      .clk   (clk),        .reset (reset),
      .stb   (gpio_stb),   .we    (gpio_we),    .adr (gpio_adr),
      .sel   (gpio_sel),   .dat_w (gpio_dat_w),
      .dat_r (gpio_dat_r), .ack   (gpio_ack),
      .p0    (p0),         .p1    (p1)
   );

endmodule

`default_nettype wire

//--- nrv_tcm_ram.sv
//**************************************************
// tcm_words must be a power of two, at most 16384
// Smaller depths alias inside the 64 KiB region
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module nrv_tcm_ram #(
   parameter int tcm_words = 16384   // Depth in 32-bit words
) (
   input  logic           clk,
   input  logic           reset,
   input  logic           stb,
   input  logic           we,
   input  nrv_pkg::addr_t adr,
   input  nrv_pkg::sel_t  sel,
   input  nrv_pkg::data_t dat_w,
   output nrv_pkg::data_t dat_r,
   output logic           ack
);

   import nrv_pkg::*;

   localparam int word_bits = $clog2(tcm_words);

   data_t                mem [tcm_words];
   logic [word_bits-1:0] idx;      // Word index, byte offset dropped
   logic                 access;   // New request, ack cycle excluded

   assign idx    = adr[word_bits+1:2];
   assign access = stb && !ack;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= access;   // One-cycle ack
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         if (we) begin
            for (int b = 0; b < 4; b++) begin
               if (sel[b]) begin
                  mem[idx][8*b +: 8] <= dat_w[8*b +: 8];
               end
            end
         end
         dat_r <= mem[idx];   // Old data on a write
      end
   end

endmodule

`default_nettype wire

//--- tb_nrv_soc.sv
//**************************************************
// RAMs built with 256 words, so RAM addresses alias above bit 9
// Both masters driven on the falling edge, outputs checked there too
//**************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_nrv_soc;

   import nrv_pkg::*;

   localparam int    clk_period     = 8;
   localparam int    reset_cycles   = 10;
   localparam int    n_xfers        = 210;   // Bus transfers issued below, rounded up
   localparam int    timeout_cycles = reset_cycles + n_xfers * 10;
   localparam addr_t gpio_base      = 32'h0002_0000;
   localparam addr_t none_base      = 32'h0003_0000;   // Region 3

   logic        clk = 1'b0;
   logic        reset;
   logic        iside_stb, iside_ack, dside_stb, dside_we, dside_ack;
   addr_t       iside_adr, dside_adr;
   sel_t        dside_sel;
   data_t       dside_dat_w, iside_dat_r, dside_dat_r;
   gpio_t       p0, p1;
   data_t       iside_exp, dside_exp;   // Expected data of the open transfer
   data_t       code_mem [256];         // RAM models, index modulo 256
   data_t       data_mem [256];
   gpio_t       p0_model;
   logic [31:0] rng = 32'h456a_de3a;
   int          ic, dc;                 // Cycles to ack, per master

   nrv_soc_top #(.tcm_words(256)) u_dut (.*);

   always #(clk_period / 2) clk = ~clk;

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic logic [31:0] next_rand();
      rng = xorshift32(rng);
      return rng;
   endfunction

   // Random bits 15:10 exercise the aliasing
   function automatic addr_t ram_addr(input region_t r, input int idx);
      logic [31:0] hi;
      hi = next_rand();
      return {14'd0, r, hi[5:0], idx[7:0], 2'b00};
   endfunction

   // Memory map rules applied to the models
   function automatic data_t expected_read(input addr_t adr);
      case (region_t'(adr[REGION_MSB:REGION_LSB]))
         REGION_TCM0: return code_mem[adr[9:2]];
         REGION_TCM1: return data_mem[adr[9:2]];
         REGION_PERIPH: begin
            if (adr[15:2] == GPIO_OUT_OFFSET[15:2]) return {16'h0000, p0_model};
            if (adr[15:2] == GPIO_IN_OFFSET[15:2]) return {16'h0000, p1};
            return '0;   // Unused offset
         end
         default: return '0;
      endcase
   endfunction

   function automatic void model_write(input addr_t adr, input sel_t sel, input data_t dat);
      for (int b = 0; b < 4; b++) begin
         if (sel[b]) begin
            case (region_t'(adr[REGION_MSB:REGION_LSB]))
               REGION_TCM0: code_mem[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
               REGION_TCM1: data_mem[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
               REGION_PERIPH: begin
                  if (b < 2 && adr[15:2] == GPIO_OUT_OFFSET[15:2]) begin
                     p0_model[8*b +: 8] = dat[8*b +: 8];   // Only bytes 0 and 1 exist
                  end
               end
               default: ;   // Unmapped write dropped
            endcase
         end
      end
   endfunction

   task automatic fail_now(input string msg);
      $display("Fail at %0t ns: %s", $time, msg);
      $display("Checks failed");
      $fatal(1, "Stopped at first error");
   endtask

   task automatic check_data(input string what, input data_t got, input data_t exp);
      if (got !== exp) fail_now($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_gpio(input string what, input gpio_t got, input gpio_t exp);
      if (got !== exp) fail_now($sformatf("%s is %h, expected %h", what, got, exp));
   endtask

   task automatic check_count(input string what, input int got, input int exp);
      if (got != exp) fail_now($sformatf("%s is %0d, expected %0d", what, got, exp));
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) fail_now($sformatf("%s is %b, expected %b", what, got, exp));
   endtask

   // Called on a falling edge, returns on the falling edge after the ack edge
   task automatic iside_read(input addr_t adr, output int cycles);
      iside_exp = expected_read(adr);
      iside_adr = adr;
      iside_stb = 1'b1;
      cycles    = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (iside_ack !== 1'b1);
      @(negedge clk);   // Past the ack edge
      iside_stb = 1'b0;
   endtask

   task automatic dside_xfer(input logic we, input addr_t adr, input sel_t sel,
                             input data_t dat, output int cycles);
      dside_exp = expected_read(adr);   // Before the model takes the write
      if (we) model_write(adr, sel, dat);
      dside_we    = we;
      dside_adr   = adr;
      dside_sel   = sel;
      dside_dat_w = dat;
      dside_stb   = 1'b1;
      cycles      = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (dside_ack !== 1'b1);
      @(negedge clk);
      dside_stb = 1'b0;
   endtask

   // Read data checked in the ack cycle, writes return nothing defined
   always @(negedge clk) begin
      if (!reset && iside_ack) check_data("iside read data", iside_dat_r, iside_exp);
      if (!reset && dside_ack && !dside_we) check_data("dside read data", dside_dat_r, dside_exp);
   end

   initial begin
      #(timeout_cycles * clk_period);
      $display("Timeout: no end of test after %0d cycles, a bus ack went missing",
               timeout_cycles);
      $display("Checks failed");
      $fatal(1, "Watchdog expired");
   end

   initial begin
      addr_t a, b2;
      data_t d;
      reset       = 1'b1;
      iside_stb   = 1'b0;
      iside_adr   = '0;
      dside_stb   = 1'b0;
      dside_we    = 1'b0;
      dside_adr   = '0;
      dside_sel   = '0;
      dside_dat_w = '0;
      p1          = '0;
      p0_model    = '0;
      repeat (reset_cycles) @(negedge clk);
      reset = 1'b0;
      check_bit("iside_ack after reset", iside_ack, 1'b0);
      check_bit("dside_ack after reset", dside_ack, 1'b0);
      check_gpio("p0 after reset", p0, '0);

      // Full words first, so no byte stays unknown
      for (int r = 0; r < 2; r++) begin
         for (int n = 0; n < 32; n++) begin
            dside_xfer(1'b1, ram_addr(region_t'(r[1:0]), n), 4'hf, next_rand(), dc);
            check_count("word write cycles", dc, 2);
         end
      end
      for (int n = 0; n < 40; n++) begin
         d = next_rand();
         a = ram_addr(region_t'({1'b0, d[4]}), int'(d[9:5]));
         dside_xfer(1'b1, a, d[3:0], next_rand(), dc);
         check_count("byte write cycles", dc, 2);
      end
      for (int r = 0; r < 2; r++) begin
         for (int n = 0; n < 32; n++) begin
            dside_xfer(1'b0, ram_addr(region_t'(r[1:0]), n), 4'hf, '0, dc);
            check_count("dside read cycles", dc, 2);
         end
      end
      for (int n = 0; n < 16; n++) begin
         iside_read(ram_addr(REGION_TCM0, n), ic);   // Code written by dside
         check_count("iside read cycles", ic, 2);
      end

      // Same RAM in the same cycle, one waits
      for (int n = 0; n < 4; n++) begin
         a  = ram_addr(REGION_TCM0, n);
         b2 = ram_addr(REGION_TCM0, n + 8);
         fork
            iside_read(a, ic);
            dside_xfer(1'b0, b2, 4'hf, '0, dc);
         join
         check_bit("second ack after first", (ic == 2 && dc > 2) || (dc == 2 && ic > 2), 1'b1);
      end
      // Different slaves, no waiting
      for (int n = 0; n < 2; n++) begin
         a  = ram_addr(REGION_TCM0, n);
         b2 = (n == 0) ? ram_addr(REGION_TCM1, n) : gpio_base + GPIO_OUT_OFFSET;
         fork
            iside_read(a, ic);
            dside_xfer(1'b0, b2, 4'hf, '0, dc);
         join
         check_count("parallel iside cycles", ic, 2);
         check_count("parallel dside cycles", dc, 2);
      end

      dside_xfer(1'b1, gpio_base + GPIO_OUT_OFFSET, 4'b0001, next_rand(), dc);
      check_gpio("p0 after byte 0 write", p0, p0_model);
      dside_xfer(1'b1, gpio_base + GPIO_OUT_OFFSET, 4'b1110, next_rand(), dc);
      check_gpio("p0 after byte 1 write", p0, p0_model);   // Bytes 2, 3 dropped
      dside_xfer(1'b0, gpio_base + GPIO_OUT_OFFSET, 4'hf, '0, dc);
      check_count("gpio read cycles", dc, 2);
      d  = next_rand();
      p1 = d[15:0];
      repeat (4) @(negedge clk);   // Through the synchronizer
      dside_xfer(1'b0, gpio_base + GPIO_IN_OFFSET, 4'hf, '0, dc);

      dside_xfer(1'b1, none_base, 4'hf, next_rand(), dc);
      check_count("unmapped write cycles", dc, 1);
      dside_xfer(1'b0, none_base, 4'hf, '0, dc);
      check_count("unmapped read cycles", dc, 1);
      iside_read(none_base + 32'd4, ic);
      check_count("unmapped iside cycles", ic, 1);
      // Same low bits in every slave, models untouched
      dside_xfer(1'b0, ram_addr(REGION_TCM0, 0), 4'hf, '0, dc);
      dside_xfer(1'b0, ram_addr(REGION_TCM1, 0), 4'hf, '0, dc);
      dside_xfer(1'b0, gpio_base + GPIO_OUT_OFFSET, 4'hf, '0, dc);
      check_gpio("p0 after unmapped write", p0, p0_model);

      repeat (2) @(negedge clk);
      $display("All checks passed");
      $finish;
   end

endmodule

`default_nettype wire
